/* common/bru_cfg.svh */
`ifndef BRU_CFG_SVH
`define BRU_CFG_SVH

// datapath widths
`define BRU_XLEN     32
`define BRU_VADDR_W  32

// physical register ids with x0 hardwired to zero
`define BRU_RNID_W   6
`define BRU_PHY_REGS (1 << `BRU_RNID_W)

// register file read ports used by the pipe
`define BRU_RD_PORTS 2

// write-back bus carries the external ports first, then the pipe's own port
`define BRU_EXT_WR_PORTS 2
`define BRU_TGT_BUS_SIZE (`BRU_EXT_WR_PORTS + 1)

// one-hot branch tags as wide as the mask
`define BRU_BRTAG_W  4

`endif

/* common/bru_pkg.sv */
`include "bru_cfg.svh"

package bru_pkg;

  typedef enum logic [2:0] {
    OP_EQ,
    OP_NE,
    OP_LT,
    OP_GE,
    OP_LTU,
    OP_GEU,
    OP_JUMP
  } bru_op_t;

  typedef enum logic [1:0] {
    IMM_B,
    IMM_J,
    IMM_I
  } bru_imm_t;

  // conditional branch layout
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  // jal layout
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // jalr layout
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef union packed {
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
    i_fmt_t i_fmt;
  } inst_u;

  typedef struct packed {
    logic                    valid;
    logic [`BRU_RNID_W-1:0] rnid;
  } src_reg_t;

  typedef struct packed {
    logic                     valid;
    inst_u                    inst;
    logic [`BRU_VADDR_W-1:0] pc_addr;
    logic                     is_rvc;
    src_reg_t [1:0]           rd_regs;
    logic                     wr_valid;
    logic [`BRU_RNID_W-1:0]  wr_rnid;
    logic                     wr_is_x0;
    logic [`BRU_BRTAG_W-1:0] brtag;
    logic [`BRU_BRTAG_W-1:0] br_mask;
    logic                     pred_taken;
    logic [`BRU_VADDR_W-1:0] pred_target;
  } issue_t;

  typedef struct packed {
    logic                    valid;
    logic [`BRU_RNID_W-1:0] rd_rnid;
    logic [`BRU_XLEN-1:0]   rd_data;
  } phy_wr_t;

  typedef struct packed {
    logic                    valid;
    logic [`BRU_RNID_W-1:0] rd_rnid;
  } early_wr_t;

  typedef struct packed {
    logic                     update;
    logic                     dead;
    logic                     taken;
    logic                     mispredict;
    logic [`BRU_VADDR_W-1:0] pc_vaddr;
    logic [`BRU_VADDR_W-1:0] target_vaddr;
    logic [`BRU_BRTAG_W-1:0] brtag;
    logic [`BRU_BRTAG_W-1:0] br_mask;
  } br_upd_t;

  typedef struct packed {
    bru_op_t  op;
    bru_imm_t imm;
    logic     wr_rd;
  } pipe_ctrl_t;

endpackage

/* bru/bru_decoder.sv */
`timescale 1ns/100ps

`include "bru_cfg.svh"

module bru_decoder
  import bru_pkg::*;
(
  input  inst_u      i_inst,
  output pipe_ctrl_t o_ctrl
);

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  always_comb begin
    o_ctrl.op    = OP_EQ;
    o_ctrl.imm   = IMM_B;
    o_ctrl.wr_rd = 1'b0;

    case (i_inst.b_fmt.opcode)
      OPC_JAL: begin
        o_ctrl.op    = OP_JUMP;
        o_ctrl.imm   = IMM_J;
        o_ctrl.wr_rd = 1'b1;
      end
      OPC_JALR: begin
        o_ctrl.op    = OP_JUMP;
        o_ctrl.imm   = IMM_I;  // target from rs1
        o_ctrl.wr_rd = 1'b1;
      end
      OPC_BRANCH: begin
        o_ctrl.imm = IMM_B;
        case (i_inst.b_fmt.funct3)
          3'b000:  o_ctrl.op = OP_EQ;
          3'b001:  o_ctrl.op = OP_NE;
          3'b100:  o_ctrl.op = OP_LT;
          3'b101:  o_ctrl.op = OP_GE;
          3'b110:  o_ctrl.op = OP_LTU;
          3'b111:  o_ctrl.op = OP_GEU;
          default: o_ctrl.op = OP_EQ;  // reserved encodings
        endcase
      end
      default: begin
        o_ctrl.op    = OP_EQ;
        o_ctrl.imm   = IMM_B;
        o_ctrl.wr_rd = 1'b0;
      end
    endcase
  end

endmodule

/* bru/bru_operand_fwd.sv */
`timescale 1ns/100ps

`include "bru_cfg.svh"

module bru_operand_fwd
  import bru_pkg::*;
(
  input  src_reg_t             i_src,
  input  phy_wr_t              i_bus [`BRU_TGT_BUS_SIZE],
  input  logic [`BRU_XLEN-1:0] i_rf_data,
  output logic [`BRU_XLEN-1:0] o_data,
  output logic                 o_fwd_hit
);

  logic [`BRU_TGT_BUS_SIZE-1:0] w_hit;
  logic [`BRU_XLEN-1:0]         w_fwd_data;

  generate
    for (genvar p = 0; p < `BRU_TGT_BUS_SIZE; p++) begin : g_match
      assign w_hit[p] = i_src.valid & i_bus[p].valid &
                        (i_src.rnid == i_bus[p].rd_rnid) &
                        (i_src.rnid != '0);  // x0 never forwards
    end
  endgenerate

  // at most one port writes a given rnid per cycle
  always_comb begin
    w_fwd_data = '0;
    for (int p = 0; p < `BRU_TGT_BUS_SIZE; p++) begin
      w_fwd_data = w_fwd_data | ({`BRU_XLEN{w_hit[p]}} & i_bus[p].rd_data);
    end
  end

  assign o_fwd_hit = |w_hit;
  assign o_data    = o_fwd_hit ? w_fwd_data : i_rf_data;

endmodule

/* bru/bru_pipe.sv */
`timescale 1ns/100ps

`include "bru_cfg.svh"

module bru_pipe
  import bru_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  input  issue_t               i_issue,
  input  phy_wr_t              i_bus [`BRU_TGT_BUS_SIZE],

  output src_reg_t             o_rd_req [`BRU_RD_PORTS],
  input  logic [`BRU_XLEN-1:0] i_rd_data [`BRU_RD_PORTS],

  output early_wr_t            o_early_wr,
  output phy_wr_t              o_phy_wr,
  output logic                 o_done,
  output br_upd_t              o_br_upd
);

  localparam int VW = `BRU_VADDR_W;

  pipe_ctrl_t                w_ex0_ctrl;
  logic                      w_ex0_flush;

  logic                      r_ex1_valid;
  logic                      r_ex1_dead;
  issue_t                    r_ex1_issue;
  pipe_ctrl_t                r_ex1_ctrl;
  logic                      w_ex1_flush;

  logic                      r_ex2_valid;
  logic                      r_ex2_dead;
  issue_t                    r_ex2_issue;
  pipe_ctrl_t                r_ex2_ctrl;
  logic [`BRU_XLEN-1:0]      r_ex2_rs_data [`BRU_RD_PORTS];
  logic [`BRU_XLEN-1:0]      w_ex2_rs_data [`BRU_RD_PORTS];
  logic                      w_ex2_flush;
  logic                      w_ex2_taken;
  logic [VW-1:0]             w_ex2_offset_b;
  logic [VW-1:0]             w_ex2_offset_j;
  logic [VW-1:0]             w_ex2_jalr_sum;
  logic [VW-1:0]             w_ex2_br_vaddr;

  logic                      r_ex3_valid;
  logic                      r_ex3_dead;
  issue_t                    r_ex3_issue;
  pipe_ctrl_t                r_ex3_ctrl;
  logic                      r_ex3_taken;
  logic [VW-1:0]             r_ex3_br_vaddr;
  logic [VW-1:0]             w_ex3_seq_pc;

  // younger op depends on a branch that just mispredicted
  function automatic logic is_flushed(input logic [`BRU_BRTAG_W-1:0] mask,
                                      input br_upd_t upd);
    return upd.update & upd.mispredict & ~upd.dead & (|(mask & upd.brtag));
  endfunction

  bru_decoder bru_decoder_i (
    .i_inst (i_issue.inst),
    .o_ctrl (w_ex0_ctrl)
  );

  assign w_ex0_flush = i_issue.valid & is_flushed(i_issue.br_mask, o_br_upd);
  assign w_ex1_flush = r_ex1_valid & is_flushed(r_ex1_issue.br_mask, o_br_upd);
  assign w_ex2_flush = r_ex2_valid & is_flushed(r_ex2_issue.br_mask, o_br_upd);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex1_dead  <= 1'b0;
      r_ex2_valid <= 1'b0;
      r_ex2_dead  <= 1'b0;
      r_ex3_valid <= 1'b0;
      r_ex3_dead  <= 1'b0;
    end else begin
      r_ex1_valid <= i_issue.valid;
      r_ex1_dead  <= w_ex0_flush;
      r_ex2_valid <= r_ex1_valid;
      r_ex2_dead  <= r_ex1_dead | w_ex1_flush;
      r_ex3_valid <= r_ex2_valid;
      r_ex3_dead  <= r_ex2_dead | w_ex2_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_issue    <= i_issue;
    r_ex1_ctrl     <= w_ex0_ctrl;
    r_ex2_issue    <= r_ex1_issue;
    r_ex2_ctrl     <= r_ex1_ctrl;
    r_ex2_rs_data  <= i_rd_data;
    r_ex3_issue    <= r_ex2_issue;
    r_ex3_ctrl     <= r_ex2_ctrl;
    r_ex3_taken    <= w_ex2_taken;
    r_ex3_br_vaddr <= w_ex2_br_vaddr;
  end

  // EX1 register read and wake-up
  generate
    for (genvar k = 0; k < `BRU_RD_PORTS; k++) begin : g_src
      assign o_rd_req[k].valid = r_ex1_valid & r_ex1_issue.rd_regs[k].valid;
      assign o_rd_req[k].rnid  = r_ex1_issue.rd_regs[k].rnid;

      bru_operand_fwd bru_operand_fwd_i (
        .i_src     (r_ex2_issue.rd_regs[k]),
        .i_bus     (i_bus),
        .i_rf_data (r_ex2_rs_data[k]),
        .o_data    (w_ex2_rs_data[k]),
        .o_fwd_hit ()
      );
    end
  endgenerate

  assign o_early_wr.valid   = r_ex1_valid & r_ex1_issue.wr_valid;
  assign o_early_wr.rd_rnid = r_ex1_issue.wr_rnid;

  // EX2 resolve
  always_comb begin
    case (r_ex2_ctrl.op)
      OP_EQ:   w_ex2_taken = w_ex2_rs_data[0] == w_ex2_rs_data[1];
      OP_NE:   w_ex2_taken = w_ex2_rs_data[0] != w_ex2_rs_data[1];
      OP_LT:   w_ex2_taken = $signed(w_ex2_rs_data[0]) <  $signed(w_ex2_rs_data[1]);
      OP_GE:   w_ex2_taken = $signed(w_ex2_rs_data[0]) >= $signed(w_ex2_rs_data[1]);
      OP_LTU:  w_ex2_taken = w_ex2_rs_data[0] <  w_ex2_rs_data[1];
      OP_GEU:  w_ex2_taken = w_ex2_rs_data[0] >= w_ex2_rs_data[1];
      OP_JUMP: w_ex2_taken = 1'b1;
      default: w_ex2_taken = 1'b0;
    endcase
  end

  assign w_ex2_offset_b = {{(VW-13){r_ex2_issue.inst.b_fmt.imm12}},
                           r_ex2_issue.inst.b_fmt.imm12,
                           r_ex2_issue.inst.b_fmt.imm11,
                           r_ex2_issue.inst.b_fmt.imm10_5,
                           r_ex2_issue.inst.b_fmt.imm4_1,
                           1'b0};
  assign w_ex2_offset_j = {{(VW-21){r_ex2_issue.inst.j_fmt.imm20}},
                           r_ex2_issue.inst.j_fmt.imm20,
                           r_ex2_issue.inst.j_fmt.imm19_12,
                           r_ex2_issue.inst.j_fmt.imm11,
                           r_ex2_issue.inst.j_fmt.imm10_1,
                           1'b0};
  assign w_ex2_jalr_sum = w_ex2_rs_data[0][VW-1:0] +
                          {{(VW-12){r_ex2_issue.inst.i_fmt.imm12[11]}},
                           r_ex2_issue.inst.i_fmt.imm12};

  always_comb begin
    case (r_ex2_ctrl.imm)
      IMM_B:   w_ex2_br_vaddr = r_ex2_issue.pc_addr + w_ex2_offset_b;
      IMM_J:   w_ex2_br_vaddr = r_ex2_issue.pc_addr + w_ex2_offset_j;
      IMM_I:   w_ex2_br_vaddr = {w_ex2_jalr_sum[VW-1:1], 1'b0};  // jalr drops bit 0
      default: w_ex2_br_vaddr = r_ex2_issue.pc_addr;
    endcase
  end

  // EX3 report
  assign w_ex3_seq_pc = r_ex3_issue.pc_addr + (r_ex3_issue.is_rvc ? VW'(2) : VW'(4));

  assign o_phy_wr.valid   = r_ex3_valid & r_ex3_ctrl.wr_rd & r_ex3_issue.wr_valid &
                            ~r_ex3_issue.wr_is_x0 & ~r_ex3_dead;
  assign o_phy_wr.rd_rnid = r_ex3_issue.wr_rnid;
  assign o_phy_wr.rd_data = `BRU_XLEN'(w_ex3_seq_pc);  // link value

  assign o_done = r_ex3_valid;

  assign o_br_upd.update       = r_ex3_valid;
  assign o_br_upd.dead         = r_ex3_dead;
  assign o_br_upd.taken        = r_ex3_taken;
  assign o_br_upd.mispredict   = (r_ex3_taken != r_ex3_issue.pred_taken) |
                                 (r_ex3_taken & (r_ex3_br_vaddr != r_ex3_issue.pred_target));
  assign o_br_upd.pc_vaddr     = r_ex3_issue.pc_addr;
  assign o_br_upd.target_vaddr = r_ex3_taken ? r_ex3_br_vaddr : w_ex3_seq_pc;
  assign o_br_upd.brtag        = r_ex3_issue.brtag;
  assign o_br_upd.br_mask      = r_ex3_issue.br_mask;

endmodule

/* logic/bru_regfile.sv */
`timescale 1ns/100ps

`include "bru_cfg.svh"

module bru_regfile
  import bru_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  input  phy_wr_t              i_wr [`BRU_TGT_BUS_SIZE],

  input  src_reg_t             i_rd_req [`BRU_RD_PORTS],
  output logic [`BRU_XLEN-1:0] o_rd_data [`BRU_RD_PORTS]
);

  logic [`BRU_XLEN-1:0] r_regs [`BRU_PHY_REGS];

  // later bus ports win on a same-rnid collision
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < `BRU_PHY_REGS; r++) begin
        r_regs[r] <= '0;
      end
    end else begin
      for (int p = 0; p < `BRU_TGT_BUS_SIZE; p++) begin
        if (i_wr[p].valid && (i_wr[p].rd_rnid != '0)) begin
          r_regs[i_wr[p].rd_rnid] <= i_wr[p].rd_data;
        end
      end
    end
  end

  generate
    for (genvar k = 0; k < `BRU_RD_PORTS; k++) begin : g_rd
      always_comb begin
        o_rd_data[k] = r_regs[i_rd_req[k].rnid];
        for (int p = 0; p < `BRU_TGT_BUS_SIZE; p++) begin
          if (i_wr[p].valid && (i_wr[p].rd_rnid == i_rd_req[k].rnid)) begin
            o_rd_data[k] = i_wr[p].rd_data;  // write-through
          end
        end
        if (!i_rd_req[k].valid || (i_rd_req[k].rnid == '0)) begin
          o_rd_data[k] = '0;
        end
      end
    end
  endgenerate

endmodule

/* logic/bru_top.sv */
`timescale 1ns/100ps

`include "bru_cfg.svh"

module bru_top
  import bru_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,

  input  issue_t    i_issue,
  input  phy_wr_t   i_ext_wr [`BRU_EXT_WR_PORTS],

  output early_wr_t o_early_wr,
  output phy_wr_t   o_phy_wr,
  output logic      o_done,
  output br_upd_t   o_br_upd
);

  phy_wr_t              w_bus [`BRU_TGT_BUS_SIZE];
  src_reg_t             w_rd_req [`BRU_RD_PORTS];
  logic [`BRU_XLEN-1:0] w_rd_data [`BRU_RD_PORTS];

  // external ports first, pipe link write last
  generate
    for (genvar p = 0; p < `BRU_EXT_WR_PORTS; p++) begin : g_bus
      assign w_bus[p] = i_ext_wr[p];
    end
  endgenerate

  assign w_bus[`BRU_EXT_WR_PORTS] = o_phy_wr;

  bru_pipe bru_pipe_i (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_issue    (i_issue),
    .i_bus      (w_bus),
    .o_rd_req   (w_rd_req),
    .i_rd_data  (w_rd_data),
    .o_early_wr (o_early_wr),
    .o_phy_wr   (o_phy_wr),
    .o_done     (o_done),
    .o_br_upd   (o_br_upd)
  );

  bru_regfile bru_regfile_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_wr      (w_bus),
    .i_rd_req  (w_rd_req),
    .o_rd_data (w_rd_data)
  );

endmodule

/* testbench/bru_model.svh */
`ifndef BRU_MODEL_SVH
`define BRU_MODEL_SVH

// one in-flight instruction
typedef struct {
  issue_t      iss;
  int          kind;  // 0..5 beq..bgeu, 6 jal, 7 jalr
  logic [31:0] imm;
  logic        dead;
  logic [31:0] a;
  logic [31:0] b;
} slot_t;

logic [31:0] shadow_regs [64];
slot_t       slots [4];  // indexed by EX stage

function automatic slot_t empty_slot();
  slot_t s;
  s.iss  = '0;
  s.kind = 0;
  s.imm  = '0;
  s.dead = 1'b0;
  s.a    = '0;
  s.b    = '0;
  return s;
endfunction

function automatic void reset_model();
  for (int r = 0; r < 64; r++) begin
    shadow_regs[r] = '0;
  end
  for (int i = 0; i < 4; i++) begin
    slots[i] = empty_slot();
  end
endfunction

function automatic logic [31:0] seq_pc(issue_t iss);
  return iss.pc_addr + (iss.is_rvc ? 32'd2 : 32'd4);
endfunction

function automatic logic cond_taken(slot_t s);
  case (s.kind)
    0:       return s.a == s.b;
    1:       return s.a != s.b;
    2:       return $signed(s.a) < $signed(s.b);
    3:       return $signed(s.a) >= $signed(s.b);
    4:       return s.a < s.b;
    5:       return s.a >= s.b;
    default: return 1'b1;  // jumps
  endcase
endfunction

function automatic logic [31:0] final_target(slot_t s);
  if (!cond_taken(s)) return seq_pc(s.iss);
  if (s.kind == 7) return (s.a + s.imm) & 32'hffff_fffe;
  return s.iss.pc_addr + s.imm;
endfunction

function automatic logic mispredicted(slot_t s);
  logic taken;
  taken = cond_taken(s);
  return (taken != s.iss.pred_taken) || (taken && (final_target(s) != s.iss.pred_target));
endfunction

function automatic logic link_writes(slot_t s);
  return s.iss.valid && (s.kind >= 6) && s.iss.wr_valid && !s.iss.wr_is_x0 && !s.dead;
endfunction

function automatic logic [31:0] read_operand(src_reg_t src);
  return (src.valid && (src.rnid != 0)) ? shadow_regs[src.rnid] : 32'd0;
endfunction

function automatic void advance_slots();
  for (int i = 3; i > 0; i--) begin
    slots[i] = slots[i-1];
  end
  slots[0] = empty_slot();
endfunction

// a live mispredict in EX3 kills masked younger ops
function automatic void apply_flush();
  logic [3:0] tag;
  tag = slots[3].iss.brtag;
  if (slots[3].iss.valid && !slots[3].dead && mispredicted(slots[3])) begin
    for (int i = 0; i < 3; i++) begin
      if (slots[i].iss.valid && (|(slots[i].iss.br_mask & tag))) slots[i].dead = 1'b1;
    end
  end
endfunction

// bus writes of this cycle, then EX2 picks up its operands
function automatic void apply_bus();
  for (int p = 0; p < `BRU_EXT_WR_PORTS; p++) begin
    if (ext_wr[p].valid && (ext_wr[p].rd_rnid != 0)) begin
      shadow_regs[ext_wr[p].rd_rnid] = ext_wr[p].rd_data;
    end
  end
  if (link_writes(slots[3])) shadow_regs[slots[3].iss.wr_rnid] = seq_pc(slots[3].iss);
  slots[2].a = read_operand(slots[2].iss.rd_regs[0]);
  slots[2].b = read_operand(slots[2].iss.rd_regs[1]);
endfunction

function automatic logic in_flight();
  return slots[0].iss.valid | slots[1].iss.valid | slots[2].iss.valid | slots[3].iss.valid;
endfunction

`endif

/* testbench/bru_tb.sv */
`timescale 1ns/100ps

`include "bru_cfg.svh"

module bru_tb
  import bru_pkg::*;
();

  logic      clk;
  logic      reset_n;
  issue_t    issue;
  phy_wr_t   ext_wr [`BRU_EXT_WR_PORTS];
  early_wr_t early_wr;
  phy_wr_t   phy_wr;
  logic      done;
  br_upd_t   br_upd;
  int        dead_cnt;
  int        link_cnt;

`include "bru_model.svh"

  bru_top bru_top_i (
    .i_clk      (clk),
    .i_reset_n  (reset_n),
    .i_issue    (issue),
    .i_ext_wr   (ext_wr),
    .o_early_wr (early_wr),
    .o_phy_wr   (phy_wr),
    .o_done     (done),
    .o_br_upd   (br_upd)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // boundary-heavy data for the compares
  function automatic logic [31:0] edge_value();
    case ($urandom % 8)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'h7fff_ffff;
      3:       return 32'h8000_0000;
      4:       return 32'hffff_ffff;
      5:       return 32'h8000_0001;
      default: return $urandom;
    endcase
  endfunction

  function automatic src_reg_t pick_src();
    src_reg_t src;
    src.valid = ($urandom % 8) != 0;
    case ($urandom % 8)
      0:       src.rnid = '0;
      1:       src.rnid = 6'(48 + $urandom % 8);  // link targets
      2:       src.rnid = 6'(8 + $urandom % 40);
      default: src.rnid = 6'(1 + $urandom % 7);
    endcase
    return src;
  endfunction

  task automatic check_outputs();
    slot_t s;
    logic  wr_exp;
    logic  early_exp;
    s = slots[3];
    wr_exp = link_writes(s);
    check_value("o_done", done, s.iss.valid);
    check_value("update", br_upd.update, s.iss.valid);
    check_value("phy_wr valid", phy_wr.valid, wr_exp);
    if (s.iss.valid) begin
      check_value("dead", br_upd.dead, s.dead);
      check_value("taken", br_upd.taken, cond_taken(s));
      check_value("target_vaddr", br_upd.target_vaddr, final_target(s));
      check_value("mispredict", br_upd.mispredict, mispredicted(s));
      check_value("pc_vaddr", br_upd.pc_vaddr, s.iss.pc_addr);
      check_value("brtag", br_upd.brtag, s.iss.brtag);
      check_value("br_mask", br_upd.br_mask, s.iss.br_mask);
      if (s.dead) dead_cnt++;
    end
    if (wr_exp) begin
      check_value("link rnid", phy_wr.rd_rnid, s.iss.wr_rnid);
      check_value("link data", phy_wr.rd_data, seq_pc(s.iss));
      link_cnt++;
    end
    early_exp = slots[1].iss.valid & slots[1].iss.wr_valid;
    check_value("early_wr valid", early_wr.valid, early_exp);
    if (early_exp) check_value("early_wr rnid", early_wr.rd_rnid, slots[1].iss.wr_rnid);
  endtask

  task automatic make_issue(input bit allow);
    issue_t      iss;
    slot_t       s;
    logic [31:0] r;
    logic [31:0] imm;
    logic [4:0]  rd;
    logic [2:0]  f3;
    iss = '0;
    s = empty_slot();
    if (allow && (($urandom % 4) != 0)) begin
      s.kind = $urandom % 8;
      r = $urandom;
      rd = 5'($urandom);
      f3 = 3'((s.kind < 2) ? s.kind : s.kind + 2);  // beq bne blt bge bltu bgeu
      iss.valid = 1'b1;
      iss.is_rvc = 1'($urandom);
      iss.pc_addr = $urandom & 32'hffff_fffe;
      if (!iss.is_rvc) iss.pc_addr[1] = 1'b0;
      iss.rd_regs[0] = pick_src();
      iss.rd_regs[1] = pick_src();
      case (s.kind)
        6: begin
          imm = {{11{r[19]}}, r[19:0], 1'b0};
          iss.inst = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
          iss.rd_regs = '0;
        end
        7: begin
          imm = {{20{r[11]}}, r[11:0]};
          iss.inst = {imm[11:0], r[16:12], 3'b000, rd, 7'b1100111};
          iss.rd_regs[1] = '0;
        end
        default: begin
          imm = {{19{r[11]}}, r[11:0], 1'b0};
          iss.inst = {imm[12], imm[10:5], r[21:17], r[26:22], f3, imm[4:1], imm[11],
                      7'b1100011};
        end
      endcase
      if (s.kind >= 6) begin
        iss.wr_valid = 1'b1;
        iss.wr_is_x0 = ($urandom % 4) == 0;
        iss.wr_rnid = iss.wr_is_x0 ? 6'd0 : 6'(48 + $urandom % 16);
      end
      iss.brtag = 4'(1 << ($urandom % 4));
      iss.br_mask = 4'($urandom & $urandom);
      iss.pred_taken = 1'($urandom);
      iss.pred_target = ($urandom % 2) ? iss.pc_addr + imm : $urandom;
      s.imm = imm;
    end
    s.iss = iss;
    slots[0] = s;
    issue = iss;
  endtask

  task automatic drive_ext_writes();
    phy_wr_t w;
    for (int p = 0; p < `BRU_EXT_WR_PORTS; p++) begin
      w = '0;
      if ($urandom % 2) begin
        w.valid = 1'b1;
        w.rd_rnid = (($urandom % 4) == 0) ? 6'(8 + $urandom % 40) : 6'($urandom % 8);
        w.rd_data = edge_value();
      end
      // one writer per rnid per cycle
      if ((p > 0) && ext_wr[0].valid && (w.rd_rnid == ext_wr[0].rd_rnid)) w.valid = 1'b0;
      ext_wr[p] = w;
    end
  endtask

  task automatic run_cycle(input bit allow);
    advance_slots();
    check_outputs();
    make_issue(allow);
    drive_ext_writes();
    apply_flush();
    apply_bus();
  endtask

  initial begin
    int unsigned wait_cnt;
    clk = 1'b0;
    reset_n = 1'b0;
    issue = '0;
    for (int p = 0; p < `BRU_EXT_WR_PORTS; p++) begin
      ext_wr[p] = '0;
    end
    dead_cnt = 0;
    link_cnt = 0;
    void'($urandom(32'hf9eb));
    reset_model();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    for (int c = 0; c < 2000; c++) begin
      @(negedge clk);
      run_cycle(1'b1);
    end
    wait_cnt = 0;
    while (in_flight()) begin
      @(negedge clk);
      run_cycle(1'b0);
      wait_cnt++;
      if (wait_cnt > 8) begin
        $display("tests failed");
        $fatal(1, "pipe did not drain within 8 cycles");
      end
    end
    if ((dead_cnt == 0) || (link_cnt == 0)) begin
      $display("tests failed");
      $fatal(1, "random run produced no killed instruction or no link write");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

/* filelist.f */
+incdir+common
+incdir+testbench
common/bru_pkg.sv
bru/bru_decoder.sv
bru/bru_operand_fwd.sv
bru/bru_pipe.sv
logic/bru_regfile.sv
logic/bru_top.sv
testbench/bru_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module bru_tb -f filelist.f -o Vbru_tb

# a fatal stop makes the binary return nonzero, so keep going to the log check
./obj_dir/Vbru_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation PASSED"
